/* logic/demux_pkg.sv */
package demux_pkg;

  // Field widths of the AXI channels
  parameter int unsigned IdWidth   = 4;
  parameter int unsigned AddrWidth = 16;
  parameter int unsigned DataWidth = 32;
  parameter int unsigned LenWidth  = 8;
  parameter int unsigned RespWidth = 2;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [RespWidth-1:0] resp_t;
  typedef logic [LenWidth-1:0]  len_t;

  // AW and AR word, packed as {id, addr, len}
  typedef logic [IdWidth+AddrWidth+LenWidth-1:0] ax_chan_t;

  // W word, packed as {data, last}
  typedef logic [DataWidth:0] w_chan_t;

  typedef logic [IdWidth+RespWidth-1:0] b_chan_t;  // {id, resp}

  // R word, packed as {id, data, resp, last}, so last sits in bit 0 like W
  typedef logic [IdWidth+DataWidth+RespWidth:0] r_chan_t;

endpackage

/* logic/demux_chan_if.sv */
`timescale 1ns/1ns

interface demux_chan_if #(
  parameter int unsigned NumMstPorts = 2
);

  localparam int unsigned SelWidth = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1;

  logic                valid;
  logic                ready;
  demux_pkg::ax_chan_t payload;
  logic [SelWidth-1:0] select;   // Target master port

  modport src (output valid, output payload, output select, input ready);
  modport dst (input valid, input payload, input select, output ready);

endinterface

/* logic/spill_register.sv */
`timescale 1ns/1ns

module spill_register #(
  parameter bit Bypass = 1'b0
) (
  input logic       clk_i,
  input logic       arst_n_i,
  demux_chan_if.dst in_i,
  demux_chan_if.src out_o
);

  localparam int unsigned SelWidth = $bits(in_i.select);

  if (Bypass) begin : gen_bypass
    assign out_o.valid   = in_i.valid;
    assign out_o.payload = in_i.payload;
    assign out_o.select  = in_i.select;
    assign in_i.ready    = out_o.ready;
  end else begin : gen_spill
    logic                a_full_q, b_full_q;
    logic                a_fill, a_drain, b_fill, b_drain;
    demux_pkg::ax_chan_t a_pld_q, b_pld_q;
    logic [SelWidth-1:0] a_sel_q, b_sel_q;

    // A takes input beats, B catches A's beat when the output stalls
    assign a_fill  = in_i.valid && in_i.ready;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !out_o.ready;
    assign b_drain = b_full_q && out_o.ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_pld_q <= in_i.payload;
        a_sel_q <= in_i.select;
      end
      if (b_fill) begin
        b_pld_q <= a_pld_q;
        b_sel_q <= a_sel_q;
      end
    end

    assign in_i.ready    = !a_full_q || !b_full_q;  // Registered
    assign out_o.valid   = a_full_q || b_full_q;
    assign out_o.payload = b_full_q ? b_pld_q : a_pld_q;  // B is older
    assign out_o.select  = b_full_q ? b_sel_q : a_sel_q;

    // Stalled output keeps its beat until the control side takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_o.valid && !out_o.ready |=>
        out_o.valid && $stable(out_o.payload) && $stable(out_o.select))
      else $error("spill register output changed while stalled");
  end

endmodule

/* logic/w_route_fifo.sv */
`timescale 1ns/1ns

module w_route_fifo #(
  parameter int unsigned  NumMstPorts = 2,
  parameter int unsigned  Depth       = 4,
  localparam int unsigned SelWidth    = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   push_i,
  input  logic [SelWidth-1:0]    push_sel_i,
  output logic                   full_o,
  input  logic                   slv_w_valid_i,
  input  demux_pkg::w_chan_t     slv_w_i,
  output logic                   slv_w_ready_o,
  output logic [NumMstPorts-1:0] mst_w_valid_o,
  output demux_pkg::w_chan_t     mst_w_o,
  input  logic [NumMstPorts-1:0] mst_w_ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [SelWidth-1:0]        sel_t;
  typedef logic [PtrWidth-1:0]        ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] cnt_t;

  sel_t mem_q [Depth];
  ptr_t wr_ptr_q, rd_ptr_q;
  cnt_t cnt_q;
  sel_t head;
  logic empty, pop;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty  = (cnt_q == '0);
  assign full_o = (cnt_q == cnt_t'(Depth));
  assign head   = mem_q[rd_ptr_q];

  // W has no select of its own, it follows the oldest open AW
  assign slv_w_ready_o = !empty && mst_w_ready_i[head];
  assign mst_w_o       = slv_w_i;
  assign pop           = slv_w_valid_i && slv_w_ready_o && slv_w_i[0];  // Last beat

  always_comb begin
    for (int unsigned p = 0; p < NumMstPorts; p++) begin
      mst_w_valid_o[p] = !empty && slv_w_valid_i && (head == sel_t'(p));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_sel_i;
    end
  end

  // Control must hold back AWs while the route FIFO is full
  assert property (@(posedge clk_i) disable iff (!arst_n_i) push_i |-> !full_o)
    else $error("push into full W route FIFO");

endmodule

/* logic/resp_arbiter.sv */
`timescale 1ns/1ns

module resp_arbiter #(
  parameter int unsigned  NumMstPorts = 2,
  parameter type          beat_t      = logic,
  localparam int unsigned SelWidth    = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic  [NumMstPorts-1:0] mst_valid_i,
  input  beat_t [NumMstPorts-1:0] mst_data_i,
  input  logic  [NumMstPorts-1:0] mst_last_i,
  output logic  [NumMstPorts-1:0] mst_ready_o,
  output logic                    slv_valid_o,
  output beat_t                   slv_data_o,
  input  logic                    slv_ready_i
);

  typedef logic [SelWidth-1:0] sel_t;

  sel_t last_q;   // Port granted most recently
  logic lock_q;   // Grant held for a stalled beat or an open burst
  sel_t pick;
  sel_t sel;

  // Round-robin search, walked backwards so the nearest port after last_q wins
  always_comb begin : proc_pick
    int unsigned idx;
    pick = last_q;
    for (int unsigned i = NumMstPorts; i > 0; i--) begin
      idx = (int'(last_q) + i) % NumMstPorts;
      if (mst_valid_i[idx]) begin
        pick = sel_t'(idx);
      end
    end
  end

  assign sel         = lock_q ? last_q : pick;
  assign slv_valid_o = mst_valid_i[sel];
  assign slv_data_o  = mst_data_i[sel];

  always_comb begin
    for (int unsigned p = 0; p < NumMstPorts; p++) begin
      mst_ready_o[p] = slv_ready_i && (sel == sel_t'(p));
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= sel_t'(NumMstPorts - 1);  // First search starts at port 0
      lock_q <= 1'b0;
    end else if (slv_valid_o) begin
      last_q <= sel;
      lock_q <= !(slv_ready_i && mst_last_i[sel]);
    end
  end

endmodule

/* logic/demux_ctrl.sv */
`timescale 1ns/1ns

module demux_ctrl #(
  parameter int unsigned  NumMstPorts = 2,
  parameter int unsigned  MaxTrans    = 4,
  localparam int unsigned SelWidth    = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  demux_chan_if.dst              aw_i,
  demux_chan_if.dst              ar_i,
  output logic [NumMstPorts-1:0] mst_aw_valid_o,
  output demux_pkg::ax_chan_t    mst_aw_o,
  input  logic [NumMstPorts-1:0] mst_aw_ready_i,
  output logic [NumMstPorts-1:0] mst_ar_valid_o,
  output demux_pkg::ax_chan_t    mst_ar_o,
  input  logic [NumMstPorts-1:0] mst_ar_ready_i,
  output logic                   w_push_o,
  output logic [SelWidth-1:0]    w_push_sel_o,
  input  logic                   w_full_i,
  input  logic                   b_done_i,
  input  logic                   r_done_i
);

  typedef logic [SelWidth-1:0]           sel_t;
  typedef logic [$clog2(MaxTrans+1)-1:0] cnt_t;
  typedef enum logic {IDLE, BUSY} state_e;

  // Index 0 is the write direction, index 1 the read direction
  logic [1:0]             req_valid, req_ready, room, fwd, acc, done;
  sel_t                   req_sel [2];
  logic [NumMstPorts-1:0] mst_valid [2];
  logic [NumMstPorts-1:0] mst_ready [2];

  assign req_valid    = {ar_i.valid, aw_i.valid};
  assign req_sel[0]   = aw_i.select;
  assign req_sel[1]   = ar_i.select;
  assign mst_ready[0] = mst_aw_ready_i;
  assign mst_ready[1] = mst_ar_ready_i;
  assign room         = {1'b1, !w_full_i};  // An AW also needs a W route slot
  assign done         = {r_done_i, b_done_i};

  for (genvar d = 0; d < 2; d++) begin : gen_dir
    state_e state_q;
    sel_t   port_q;   // Port of the requests still in flight
    cnt_t   cnt_q;
    cnt_t   cnt_d;

    // Same port keeps order of responses, a new port waits for the old to drain
    assign fwd[d] = req_valid[d] && room[d] &&
                    ((state_q == IDLE) ||
                     ((req_sel[d] == port_q) && (cnt_q < cnt_t'(MaxTrans))));
    assign req_ready[d] = fwd[d] && mst_ready[d][req_sel[d]];
    assign acc[d]       = req_valid[d] && req_ready[d];
    assign cnt_d        = cnt_q + cnt_t'(acc[d]) - cnt_t'(done[d]);

    always_comb begin
      for (int unsigned p = 0; p < NumMstPorts; p++) begin
        mst_valid[d][p] = fwd[d] && (req_sel[d] == sel_t'(p));
      end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q <= IDLE;
        port_q  <= '0;
        cnt_q   <= '0;
      end else begin
        cnt_q   <= cnt_d;
        state_q <= (cnt_d == '0) ? IDLE : BUSY;
        if (acc[d]) begin
          port_q <= req_sel[d];
        end
      end
    end

    // A completion must belong to a request that went out earlier
    assert property (@(posedge clk_i) disable iff (!arst_n_i) done[d] |-> cnt_q != '0)
      else $error("outstanding counter underflow in direction %0d", d);
  end

  assign aw_i.ready     = req_ready[0];
  assign ar_i.ready     = req_ready[1];
  assign mst_aw_valid_o = mst_valid[0];
  assign mst_ar_valid_o = mst_valid[1];
  assign mst_aw_o       = aw_i.payload;  // Payload goes to all ports, valid picks one
  assign mst_ar_o       = ar_i.payload;

  assign w_push_o     = acc[0];
  assign w_push_sel_o = aw_i.select;

endmodule

/* logic/axi_demux_top.sv */
`timescale 1ns/1ns

module axi_demux_top #(
  parameter int unsigned  NumMstPorts = 3,
  parameter int unsigned  MaxTrans    = 4,
  parameter bit           SpillAw     = 1'b1,
  parameter bit           SpillAr     = 1'b1,
  localparam int unsigned SelWidth    = (NumMstPorts > 1) ? $clog2(NumMstPorts) : 1
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  // Slave port
  input  logic                                     slv_aw_valid_i,
  output logic                                     slv_aw_ready_o,
  input  demux_pkg::ax_chan_t                      slv_aw_i,
  input  logic [SelWidth-1:0]                      slv_aw_select_i,
  input  logic                                     slv_w_valid_i,
  output logic                                     slv_w_ready_o,
  input  demux_pkg::w_chan_t                       slv_w_i,
  output logic                                     slv_b_valid_o,
  input  logic                                     slv_b_ready_i,
  output demux_pkg::b_chan_t                       slv_b_o,
  input  logic                                     slv_ar_valid_i,
  output logic                                     slv_ar_ready_o,
  input  demux_pkg::ax_chan_t                      slv_ar_i,
  input  logic [SelWidth-1:0]                      slv_ar_select_i,
  output logic                                     slv_r_valid_o,
  input  logic                                     slv_r_ready_i,
  output demux_pkg::r_chan_t                       slv_r_o,
  // Master ports
  output logic                [NumMstPorts-1:0]    mst_aw_valid_o,
  input  logic                [NumMstPorts-1:0]    mst_aw_ready_i,
  output demux_pkg::ax_chan_t [NumMstPorts-1:0]    mst_aw_o,
  output logic                [NumMstPorts-1:0]    mst_w_valid_o,
  input  logic                [NumMstPorts-1:0]    mst_w_ready_i,
  output demux_pkg::w_chan_t  [NumMstPorts-1:0]    mst_w_o,
  input  logic                [NumMstPorts-1:0]    mst_b_valid_i,
  output logic                [NumMstPorts-1:0]    mst_b_ready_o,
  input  demux_pkg::b_chan_t  [NumMstPorts-1:0]    mst_b_i,
  output logic                [NumMstPorts-1:0]    mst_ar_valid_o,
  input  logic                [NumMstPorts-1:0]    mst_ar_ready_i,
  output demux_pkg::ax_chan_t [NumMstPorts-1:0]    mst_ar_o,
  input  logic                [NumMstPorts-1:0]    mst_r_valid_i,
  output logic                [NumMstPorts-1:0]    mst_r_ready_o,
  input  demux_pkg::r_chan_t  [NumMstPorts-1:0]    mst_r_i
);

  demux_chan_if #(.NumMstPorts(NumMstPorts)) aw_in ();
  demux_chan_if #(.NumMstPorts(NumMstPorts)) aw_cut ();
  demux_chan_if #(.NumMstPorts(NumMstPorts)) ar_in ();
  demux_chan_if #(.NumMstPorts(NumMstPorts)) ar_cut ();

  demux_pkg::ax_chan_t    mst_aw, mst_ar;
  demux_pkg::w_chan_t     mst_w;
  logic                   w_push, w_full;
  logic [SelWidth-1:0]    w_push_sel;
  logic [NumMstPorts-1:0] r_last;

  assign aw_in.valid    = slv_aw_valid_i;
  assign aw_in.payload  = slv_aw_i;
  assign aw_in.select   = slv_aw_select_i;
  assign slv_aw_ready_o = aw_in.ready;
  assign ar_in.valid    = slv_ar_valid_i;
  assign ar_in.payload  = slv_ar_i;
  assign ar_in.select   = slv_ar_select_i;
  assign slv_ar_ready_o = ar_in.ready;

  // Request payloads are shared, the per-port valids do the steering
  assign mst_aw_o = {NumMstPorts{mst_aw}};
  assign mst_ar_o = {NumMstPorts{mst_ar}};
  assign mst_w_o  = {NumMstPorts{mst_w}};

  for (genvar p = 0; p < NumMstPorts; p++) begin : gen_r_last
    assign r_last[p] = mst_r_i[p][0];
  end

  spill_register #(.Bypass(!SpillAw)) i_aw_spill (
    .clk_i, .arst_n_i, .in_i (aw_in), .out_o (aw_cut)
  );

  spill_register #(.Bypass(!SpillAr)) i_ar_spill (
    .clk_i, .arst_n_i, .in_i (ar_in), .out_o (ar_cut)
  );

  demux_ctrl #(.NumMstPorts(NumMstPorts), .MaxTrans(MaxTrans)) i_demux_ctrl (
    .clk_i, .arst_n_i,
    .aw_i           (aw_cut),
    .ar_i           (ar_cut),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_o       (mst_aw),
    .mst_aw_ready_i (mst_aw_ready_i),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_o       (mst_ar),
    .mst_ar_ready_i (mst_ar_ready_i),
    .w_push_o       (w_push),
    .w_push_sel_o   (w_push_sel),
    .w_full_i       (w_full),
    .b_done_i       (slv_b_valid_o && slv_b_ready_i),
    .r_done_i       (slv_r_valid_o && slv_r_ready_i && slv_r_o[0])
  );

  w_route_fifo #(.NumMstPorts(NumMstPorts), .Depth(MaxTrans)) i_w_route (
    .clk_i, .arst_n_i,
    .push_i        (w_push),
    .push_sel_i    (w_push_sel),
    .full_o        (w_full),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_i       (slv_w_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_o       (mst_w),
    .mst_w_ready_i (mst_w_ready_i)
  );

  // Every B beat closes its transaction
  resp_arbiter #(.NumMstPorts(NumMstPorts), .beat_t(demux_pkg::b_chan_t)) i_b_arb (
    .clk_i, .arst_n_i,
    .mst_valid_i (mst_b_valid_i),
    .mst_data_i  (mst_b_i),
    .mst_last_i  ({NumMstPorts{1'b1}}),
    .mst_ready_o (mst_b_ready_o),
    .slv_valid_o (slv_b_valid_o),
    .slv_data_o  (slv_b_o),
    .slv_ready_i (slv_b_ready_i)
  );

  resp_arbiter #(.NumMstPorts(NumMstPorts), .beat_t(demux_pkg::r_chan_t)) i_r_arb (
    .clk_i, .arst_n_i,
    .mst_valid_i (mst_r_valid_i),
    .mst_data_i  (mst_r_i),
    .mst_last_i  (r_last),
    .mst_ready_o (mst_r_ready_o),
    .slv_valid_o (slv_r_valid_o),
    .slv_data_o  (slv_r_o),
    .slv_ready_i (slv_r_ready_i)
  );

endmodule

/* sim/tb_axi_demux.sv */
`timescale 1ns/1ns

module tb_axi_demux;

  localparam int unsigned NumPorts  = 3;
  localparam int unsigned SelWidth  = $clog2(NumPorts);
  localparam int unsigned NumWrites = 24;
  localparam int unsigned NumReads  = 24;
  localparam int unsigned NumMixed  = 16;  // Of each kind
  localparam int unsigned Timeout   = 40 * (NumWrites + NumReads + 2 * NumMixed) + 200;

  typedef logic [SelWidth-1:0] sel_t;

  logic                                clk;
  logic                                arst_n;
  logic                                slv_aw_valid;
  logic                                slv_aw_ready;
  demux_pkg::ax_chan_t                 slv_aw;
  sel_t                                slv_aw_sel;
  logic                                slv_w_valid;
  logic                                slv_w_ready;
  demux_pkg::w_chan_t                  slv_w;
  logic                                slv_b_valid;
  logic                                slv_b_ready;
  demux_pkg::b_chan_t                  slv_b;
  logic                                slv_ar_valid;
  logic                                slv_ar_ready;
  demux_pkg::ax_chan_t                 slv_ar;
  sel_t                                slv_ar_sel;
  logic                                slv_r_valid;
  logic                                slv_r_ready;
  demux_pkg::r_chan_t                  slv_r;
  logic [NumPorts-1:0]                 mst_aw_valid;
  logic [NumPorts-1:0]                 mst_w_valid;
  logic [NumPorts-1:0]                 mst_b_ready;
  logic [NumPorts-1:0]                 mst_ar_valid;
  logic [NumPorts-1:0]                 mst_r_ready;
  wire  [NumPorts-1:0]                 mst_aw_ready;
  wire  [NumPorts-1:0]                 mst_w_ready;
  wire  [NumPorts-1:0]                 mst_b_valid;
  wire  [NumPorts-1:0]                 mst_ar_ready;
  wire  [NumPorts-1:0]                 mst_r_valid;
  demux_pkg::ax_chan_t [NumPorts-1:0]  mst_aw;
  demux_pkg::ax_chan_t [NumPorts-1:0]  mst_ar;
  demux_pkg::w_chan_t  [NumPorts-1:0]  mst_w;
  wire demux_pkg::b_chan_t [NumPorts-1:0] mst_b;
  wire demux_pkg::r_chan_t [NumPorts-1:0] mst_r;

  // Stimulus still to drive, and what the scoreboard expects to see
  demux_pkg::ax_chan_t aw_stim_q[$];
  sel_t                aw_sel_q[$];
  demux_pkg::w_chan_t  w_stim_q[$];
  demux_pkg::ax_chan_t ar_stim_q[$];
  sel_t                ar_sel_q[$];
  demux_pkg::ax_chan_t exp_aw_q[$];
  sel_t                exp_aw_sel_q[$];
  demux_pkg::w_chan_t  exp_w_q[$];
  sel_t                exp_w_port_q[$];
  demux_pkg::id_t      exp_b_q[$];
  demux_pkg::ax_chan_t exp_ar_q[$];
  sel_t                exp_ar_sel_q[$];
  demux_pkg::r_chan_t  exp_r_q[$];
  sel_t                wr_port_q[$];  // Ports of writes in flight
  sel_t                rd_port_q[$];

  int unsigned err_cnt      = 0;
  int unsigned ord_err      = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;
  int unsigned cycles       = 0;
  int unsigned n_aw         = 0;
  int unsigned n_wlast      = 0;
  int unsigned n_b          = 0;
  int unsigned n_ar         = 0;
  int unsigned n_rlast      = 0;
  int unsigned tot_wr       = 0;
  int unsigned tot_rd       = 0;

  axi_demux_top #(
    .NumMstPorts (NumPorts),
    .MaxTrans    (4),
    .SpillAw     (1'b1),
    .SpillAr     (1'b1)
  ) i_axi_demux_top (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .slv_aw_valid_i  (slv_aw_valid),
    .slv_aw_ready_o  (slv_aw_ready),
    .slv_aw_i        (slv_aw),
    .slv_aw_select_i (slv_aw_sel),
    .slv_w_valid_i   (slv_w_valid),
    .slv_w_ready_o   (slv_w_ready),
    .slv_w_i         (slv_w),
    .slv_b_valid_o   (slv_b_valid),
    .slv_b_ready_i   (slv_b_ready),
    .slv_b_o         (slv_b),
    .slv_ar_valid_i  (slv_ar_valid),
    .slv_ar_ready_o  (slv_ar_ready),
    .slv_ar_i        (slv_ar),
    .slv_ar_select_i (slv_ar_sel),
    .slv_r_valid_o   (slv_r_valid),
    .slv_r_ready_i   (slv_r_ready),
    .slv_r_o         (slv_r),
    .mst_aw_valid_o  (mst_aw_valid),
    .mst_aw_ready_i  (mst_aw_ready),
    .mst_aw_o        (mst_aw),
    .mst_w_valid_o   (mst_w_valid),
    .mst_w_ready_i   (mst_w_ready),
    .mst_w_o         (mst_w),
    .mst_b_valid_i   (mst_b_valid),
    .mst_b_ready_o   (mst_b_ready),
    .mst_b_i         (mst_b),
    .mst_ar_valid_o  (mst_ar_valid),
    .mst_ar_ready_i  (mst_ar_ready),
    .mst_ar_o        (mst_ar),
    .mst_r_valid_i   (mst_r_valid),
    .mst_r_ready_o   (mst_r_ready),
    .mst_r_i         (mst_r)
  );

  function automatic demux_pkg::id_t ax_id(demux_pkg::ax_chan_t ax);
    return ax[demux_pkg::AddrWidth+demux_pkg::LenWidth +: demux_pkg::IdWidth];
  endfunction

  function automatic demux_pkg::addr_t ax_addr(demux_pkg::ax_chan_t ax);
    return ax[demux_pkg::LenWidth +: demux_pkg::AddrWidth];
  endfunction

  function automatic demux_pkg::len_t ax_len(demux_pkg::ax_chan_t ax);
    return ax[demux_pkg::LenWidth-1:0];
  endfunction

  // Read data pattern of the slave models, tagged with port and beat
  function automatic demux_pkg::data_t exp_rdata(demux_pkg::addr_t addr, int unsigned port,
                                                 int unsigned beat);
    return demux_pkg::data_t'(addr) ^ (demux_pkg::data_t'(port) << 16) ^
           (demux_pkg::data_t'(beat) << 24);
  endfunction

  task automatic report_error(string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic report_test(string name, int unsigned errs);
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %s finished with %0d errors", name, errs);
  endtask

  task automatic check_idle();
    assert (!(|mst_aw_valid) && !(|mst_w_valid) && !(|mst_ar_valid) &&
            !slv_b_valid && !slv_r_valid)
      else report_error("a valid output is high before the first request");
  endtask

  // A request valid may only rise on the port that already has traffic in flight
  task automatic check_order(logic [NumPorts-1:0] valid, sel_t busy_q[$], string dir);
    for (int unsigned p = 0; p < NumPorts; p++) begin
      foreach (busy_q[i]) begin
        assert (!valid[p] || busy_q[i] == sel_t'(p)) else begin
          $display("Ordering error at %0t ns: %s valid on port %0d while port %0d is busy",
                   $time, dir, p, busy_q[i]);
          ord_err++;
          err_cnt++;
        end
      end
    end
    assert ($onehot0(valid))
      else report_error({dir, " valid is raised on more than one port"});
  endtask

  task automatic make_writes(int unsigned n);
    demux_pkg::ax_chan_t ax;
    demux_pkg::w_chan_t  w;
    sel_t                sel;
    for (int unsigned i = 0; i < n; i++) begin
      ax  = demux_pkg::ax_chan_t'({$urandom, $urandom});
      ax[demux_pkg::LenWidth-1:0] = demux_pkg::len_t'($urandom_range(0, 3));
      sel = sel_t'($urandom_range(0, NumPorts - 1));
      aw_stim_q.push_back(ax);
      aw_sel_q.push_back(sel);
      exp_aw_q.push_back(ax);
      exp_aw_sel_q.push_back(sel);
      exp_b_q.push_back(ax_id(ax));
      for (int unsigned b = 0; b <= ax_len(ax); b++) begin
        w = {demux_pkg::data_t'($urandom), b == ax_len(ax)};
        w_stim_q.push_back(w);
        exp_w_q.push_back(w);
        exp_w_port_q.push_back(sel);
      end
    end
    tot_wr += n;
  endtask

  task automatic make_reads(int unsigned n);
    demux_pkg::ax_chan_t ax;
    sel_t                sel;
    for (int unsigned i = 0; i < n; i++) begin
      ax  = demux_pkg::ax_chan_t'({$urandom, $urandom});
      ax[demux_pkg::LenWidth-1:0] = demux_pkg::len_t'($urandom_range(0, 3));
      sel = sel_t'($urandom_range(0, NumPorts - 1));
      ar_stim_q.push_back(ax);
      ar_sel_q.push_back(sel);
      exp_ar_q.push_back(ax);
      exp_ar_sel_q.push_back(sel);
      for (int unsigned b = 0; b <= ax_len(ax); b++) begin
        exp_r_q.push_back({ax_id(ax), exp_rdata(ax_addr(ax), sel, b), 2'b00,
                           b == ax_len(ax)});
      end
    end
    tot_rd += n;
  endtask

  // Driver tasks start and end on a falling edge
  task automatic drive_aw();
    while (aw_stim_q.size() > 0) begin
      slv_aw_valid = 1'b1;
      slv_aw       = aw_stim_q.pop_front();
      slv_aw_sel   = aw_sel_q.pop_front();
      @(posedge clk);
      while (!slv_aw_ready) @(posedge clk);
      @(negedge clk);
      slv_aw_valid = 1'b0;
      if ($urandom_range(0, 3) == 0) @(negedge clk);  // Idle gap
    end
  endtask

  task automatic drive_w();
    while (w_stim_q.size() > 0) begin
      slv_w_valid = 1'b1;
      slv_w       = w_stim_q.pop_front();
      @(posedge clk);
      while (!slv_w_ready) @(posedge clk);
      @(negedge clk);
      slv_w_valid = 1'b0;
      if ($urandom_range(0, 3) == 0) @(negedge clk);
    end
  endtask

  task automatic drive_ar();
    while (ar_stim_q.size() > 0) begin
      slv_ar_valid = 1'b1;
      slv_ar       = ar_stim_q.pop_front();
      slv_ar_sel   = ar_sel_q.pop_front();
      @(posedge clk);
      while (!slv_ar_ready) @(posedge clk);
      @(negedge clk);
      slv_ar_valid = 1'b0;
      if ($urandom_range(0, 3) == 0) @(negedge clk);
    end
  endtask

  task automatic wait_drained();
    while (exp_aw_q.size() + exp_w_q.size() + exp_b_q.size() + exp_ar_q.size() +
           exp_r_q.size() > 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);  // Room for stray beats to show up
  endtask

  // Slave model behind each master port
  for (genvar p = 0; p < NumPorts; p++) begin : gen_slave
    demux_pkg::ax_chan_t wr_q[$];  // AWs still waiting for their last W
    demux_pkg::id_t      b_q[$];
    demux_pkg::ax_chan_t rd_q[$];
    int unsigned         beat;
    logic                aw_rdy, w_rdy, ar_rdy, b_vld, r_vld;
    demux_pkg::b_chan_t  b_pld;
    demux_pkg::r_chan_t  r_pld;

    assign mst_aw_ready[p] = aw_rdy;
    assign mst_w_ready[p]  = w_rdy;
    assign mst_ar_ready[p] = ar_rdy;
    assign mst_b_valid[p]  = b_vld;
    assign mst_b[p]        = b_pld;
    assign mst_r_valid[p]  = r_vld;
    assign mst_r[p]        = r_pld;

    initial begin
      beat   = 0;
      aw_rdy = 1'b0;
      w_rdy  = 1'b0;
      ar_rdy = 1'b0;
      b_vld  = 1'b0;
      r_vld  = 1'b0;
      b_pld  = '0;
      r_pld  = '0;
      forever begin
        @(posedge clk);
        if (mst_aw_valid[p] && aw_rdy) wr_q.push_back(mst_aw[p]);
        if (mst_w_valid[p] && w_rdy && mst_w[p][0] && wr_q.size() > 0) begin
          b_q.push_back(ax_id(wr_q.pop_front()));
        end
        if (b_vld && mst_b_ready[p]) void'(b_q.pop_front());
        if (mst_ar_valid[p] && ar_rdy) rd_q.push_back(mst_ar[p]);
        if (r_vld && mst_r_ready[p]) begin
          if (r_pld[0]) begin
            void'(rd_q.pop_front());
            beat = 0;
          end else begin
            beat++;
          end
        end
        @(negedge clk);
        aw_rdy = ($urandom_range(0, 3) != 0);
        w_rdy  = ($urandom_range(0, 3) != 0);
        ar_rdy = ($urandom_range(0, 3) != 0);
        b_vld  = (b_q.size() > 0);
        if (b_vld) b_pld = {b_q[0], 2'b00};  // OKAY
        r_vld  = (rd_q.size() > 0);
        if (r_vld) begin
          r_pld = {ax_id(rd_q[0]), exp_rdata(ax_addr(rd_q[0]), p, beat), 2'b00,
                   beat == ax_len(rd_q[0])};
        end
      end
    end
  end

  // Scoreboard, compares every handshake with the expected queues
  always @(posedge clk) begin : proc_scoreboard
    demux_pkg::id_t id;
    if (arst_n) begin
      check_order(mst_aw_valid, wr_port_q, "AW");
      check_order(mst_ar_valid, rd_port_q, "AR");
      for (int unsigned p = 0; p < NumPorts; p++) begin
        if (mst_aw_valid[p] && mst_aw_ready[p]) begin
          n_aw++;
          wr_port_q.push_back(sel_t'(p));
          if (exp_aw_q.size() == 0) begin
            report_error("an AW reached a master port with no request pending");
          end else begin
            compare_value("mst_aw_valid_o index", p, exp_aw_sel_q.pop_front());
            compare_value("mst_aw_o", mst_aw[p], exp_aw_q.pop_front());
          end
        end
        if (mst_w_valid[p] && mst_w_ready[p]) begin
          if (mst_w[p][0]) n_wlast++;
          if (exp_w_q.size() == 0) begin
            report_error("a W beat reached a master port with no beat pending");
          end else begin
            compare_value("mst_w_valid_o index", p, exp_w_port_q.pop_front());
            compare_value("mst_w_o", mst_w[p], exp_w_q.pop_front());
          end
        end
        if (mst_ar_valid[p] && mst_ar_ready[p]) begin
          n_ar++;
          rd_port_q.push_back(sel_t'(p));
          if (exp_ar_q.size() == 0) begin
            report_error("an AR reached a master port with no request pending");
          end else begin
            compare_value("mst_ar_valid_o index", p, exp_ar_sel_q.pop_front());
            compare_value("mst_ar_o", mst_ar[p], exp_ar_q.pop_front());
          end
        end
      end
      if (slv_b_valid && slv_b_ready) begin
        n_b++;
        if (wr_port_q.size() > 0) void'(wr_port_q.pop_front());
        if (exp_b_q.size() == 0) begin
          report_error("a B response arrived that no write asked for");
        end else begin
          id = exp_b_q.pop_front();
          compare_value("slv_b_o", slv_b, {id, 2'b00});
        end
      end
      if (slv_r_valid && slv_r_ready) begin
        if (slv_r[0]) begin
          n_rlast++;
          if (rd_port_q.size() > 0) void'(rd_port_q.pop_front());
        end
        if (exp_r_q.size() == 0) begin
          report_error("an R beat arrived that no read asked for");
        end else begin
          compare_value("slv_r_o", slv_r, exp_r_q.pop_front());
        end
      end
    end
  end

  initial begin : proc_clock
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin : proc_timeout
    while (cycles < Timeout) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", Timeout);
    $display("Test failures found");
    $finish;
  end

  initial begin : proc_main
    int unsigned start;
    void'($urandom(32'h1993));
    arst_n       = 1'b0;
    slv_aw_valid = 1'b0;
    slv_aw       = '0;
    slv_aw_sel   = '0;
    slv_w_valid  = 1'b0;
    slv_w        = '0;
    slv_b_ready  = 1'b1;
    slv_ar_valid = 1'b0;
    slv_ar       = '0;
    slv_ar_sel   = '0;
    slv_r_ready  = 1'b1;

    start = err_cnt;
    repeat (5) begin
      @(negedge clk);
      check_idle();
    end
    arst_n = 1'b1;
    repeat (3) begin
      @(posedge clk);
      check_idle();
    end
    @(negedge clk);
    report_test("reset", err_cnt - start);

    start = err_cnt;
    make_writes(NumWrites);
    fork
      drive_aw();
      drive_w();
    join
    wait_drained();
    report_test("write", err_cnt - start);

    start = err_cnt;
    make_reads(NumReads);
    drive_ar();
    wait_drained();
    report_test("read", err_cnt - start);

    start = err_cnt;
    make_writes(NumMixed);
    make_reads(NumMixed);
    fork
      drive_aw();
      drive_w();
      drive_ar();
    join
    wait_drained();
    report_test("mixed", err_cnt - start);

    report_test("ordering", ord_err);

    start = err_cnt;
    compare_value("AW transfer count", n_aw, tot_wr);
    compare_value("W last transfer count", n_wlast, tot_wr);
    compare_value("B transfer count", n_b, tot_wr);
    compare_value("AR transfer count", n_ar, tot_rd);
    compare_value("R last transfer count", n_rlast, tot_rd);
    report_test("counts", err_cnt - start);

    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
             err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* project.f */
logic/demux_pkg.sv
logic/demux_chan_if.sv
logic/spill_register.sv
logic/w_route_fifo.sv
logic/resp_arbiter.sv
logic/demux_ctrl.sv
logic/axi_demux_top.sv
sim/tb_axi_demux.sv

/* Bender.yml */
package:
  name: axi_demux

sources:
  - logic/demux_pkg.sv
  - logic/demux_chan_if.sv
  - logic/spill_register.sv
  - logic/w_route_fifo.sv
  - logic/resp_arbiter.sv
  - logic/demux_ctrl.sv
  - logic/axi_demux_top.sv
  - target: test
    files:
      - sim/tb_axi_demux.sv
